//--- block_ram_slave.sv
// On-chip block RAM slave
// Byte-lane writes, registered reads, ack one cycle after the strobe
`default_nettype none

module block_ram_slave (
	input  wire                    i_clk,
	input  wire                    i_stb,
	input  wire bus_pkg::bus_req_t i_req,
	output bus_pkg::slave_rsp_t    o_rsp
);
	import bus_pkg::*;

	bus_data_t         mem [2**MEM_AW];
	logic [MEM_AW-1:0] idx;
	logic              r_ack;
	bus_data_t         r_data;

	// Upper region bits ignored, RAM repeats
	assign idx = i_req.addr[MEM_AW-1:0];

	always_ff @(posedge i_clk)
	begin
		r_ack  <= i_stb;
		r_data <= mem[idx];
		if (i_stb && i_req.we)
		begin
			for (int i = 0; i < BUS_SW; i++)
			begin
				if (i_req.sel[i])
					mem[idx][8*i +: 8] <= i_req.data[8*i +: 8];
			end
		end
	end

	// Never stalls
	assign o_rsp = '{ack: r_ack, stall: 1'b0, data: r_data};

endmodule

`default_nettype wire

//--- bus_addr_decoder.sv
// Address decoder
// Splits the word address into the RAM, block RAM and I/O regions and
// qualifies one strobe per slave
`default_nettype none

module bus_addr_decoder (
	input  wire bus_pkg::bus_req_t i_req,
	output bus_pkg::region_e       o_region,
	output logic                   o_ram_stb,
	output logic                   o_mem_stb,
	output logic                   o_io_stb
);
	import bus_pkg::*;

	logic io_hit;

	// Only LED, ID and BUSERR exist in the page
	assign io_hit = (i_req.addr[IO_REGION_BIT-1:0] <= IO_REGION_BIT'(IO_BUSERR));

	always_comb
	begin
		o_region = REGION_NONE;
		// Top address bit is an unmapped hole
		if (!i_req.addr[BUS_AW-1])
		begin
			if (i_req.addr[RAM_REGION_BIT])
				o_region = REGION_RAM;
			else if (i_req.addr[MEM_REGION_BIT])
				o_region = REGION_MEM;
			else if (i_req.addr[IO_REGION_BIT] && io_hit)
				o_region = REGION_IO;
		end
	end

	// Per slave strobes
	assign o_ram_stb = i_req.stb && (o_region == REGION_RAM);
	assign o_mem_stb = i_req.stb && (o_region == REGION_MEM);
	assign o_io_stb  = i_req.stb && (o_region == REGION_IO);

endmodule

`default_nettype wire

//--- bus_delay_stage.sv
// Bus delay stage
// One register stage after the arbiter, request going down and
// acknowledge, error and read data coming back
`default_nettype none

module bus_delay_stage (
	input  wire                    i_clk,
	input  wire                    i_arst_n,
	input  wire bus_pkg::bus_req_t i_req,
	output bus_pkg::bus_rsp_t      o_rsp,
	output bus_pkg::bus_req_t      o_req,
	input  wire bus_pkg::bus_rsp_t i_rsp
);
	import bus_pkg::*;

	logic      r_cyc;
	logic      r_stb;
	bus_req_t  r_req;
	logic      r_ack;
	logic      r_err;
	bus_data_t r_data;
	logic      load;

	// Holding register free once its strobe has gone downstream
	assign load = !r_stb || !i_rsp.stall;

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			r_cyc <= 1'b0;
			r_stb <= 1'b0;
			r_ack <= 1'b0;
			r_err <= 1'b0;
		end
		else
		begin
			r_cyc <= i_req.cyc;
			// Abandoned cycle drops a held strobe
			if (!i_req.cyc)
				r_stb <= 1'b0;
			else if (load)
				r_stb <= i_req.stb;
			// Only answer a master still in its cycle
			r_ack <= i_req.cyc && r_cyc && i_rsp.ack;
			r_err <= i_req.cyc && r_cyc && i_rsp.err;
		end
	end

	// Request payload and read data
	always_ff @(posedge i_clk)
	begin
		if (load)
			r_req <= i_req;
		r_data <= i_rsp.data;
	end

	assign o_req = '{cyc: r_cyc, stb: r_stb, we: r_req.we,
		addr: r_req.addr, data: r_req.data, sel: r_req.sel};

	// Stall back while a request is still held
	assign o_rsp = '{ack: r_ack, stall: r_stb && i_rsp.stall,
		err: r_err, data: r_data};

endmodule

`default_nettype wire

//--- bus_error_monitor.sv
// Bus error monitor
// Flags strobes that select nothing and cycles with several acks, and
// keeps the byte address of the last faulting request
`default_nettype none

module bus_error_monitor (
	input  wire                    i_clk,
	input  wire                    i_arst_n,
	input  wire bus_pkg::bus_req_t i_req,
	input  wire bus_pkg::region_e  i_region,
	input  wire [1:0]              i_ack_count,
	input  wire                    i_ram_err,
	output logic                   o_err,
	output bus_pkg::bus_data_t     o_err_addr
);
	import bus_pkg::*;

	logic      r_nosel;
	logic      r_many;
	bus_addr_t r_addr;
	bus_data_t r_err_addr;

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			r_nosel    <= 1'b0;
			r_many     <= 1'b0;
			r_err_addr <= '0;
		end
		else
		begin
			r_nosel <= i_req.stb && (i_region == REGION_NONE);
			r_many  <= (i_ack_count > 2'd1);
			// Word address kept as a byte address
			if (o_err)
				r_err_addr <= {{(BUS_DW-BUS_AW-2){1'b0}}, r_addr, 2'b00};
		end
	end

	// Address of the last strobe
	always_ff @(posedge i_clk)
	begin
		if (i_req.stb)
			r_addr <= i_req.addr;
	end

	// External RAM errors pass without delay
	assign o_err      = i_req.cyc && (r_nosel || r_many || i_ram_err);
	assign o_err_addr = r_err_addr;

endmodule

`default_nettype wire

//--- bus_interconnect_top.sv
// System bus interconnect
// Processor and host masters, arbiter, delay stage, decoder, block RAM,
// I/O page and the external RAM port
`default_nettype none

module bus_interconnect_top (
	input  wire                      i_clk,
	input  wire                      i_arst_n,
	input  wire bus_pkg::bus_req_t   i_cpu_req,
	output bus_pkg::bus_rsp_t        o_cpu_rsp,
	input  wire bus_pkg::bus_req_t   i_host_req,
	output bus_pkg::bus_rsp_t        o_host_rsp,
	output bus_pkg::bus_req_t        o_ram_req,
	input  wire bus_pkg::slave_rsp_t i_ram_rsp,
	input  wire                      i_ram_err,
	output logic [3:0]               o_led
);
	import bus_pkg::*;

	// Master side of the delay stage
	bus_req_t   arb_req;
	bus_rsp_t   arb_rsp;
	// Decoded side
	bus_req_t   dly_req;
	bus_rsp_t   dly_rsp;
	bus_rsp_t   mux_rsp;
	region_e    region;
	logic       ram_stb;
	logic       mem_stb;
	logic       io_stb;
	slave_rsp_t mem_rsp;
	slave_rsp_t io_rsp;
	logic [1:0] ack_count;
	logic       bus_err;
	bus_data_t  err_addr;

	bus_priority_arbiter bus_priority_arbiter_inst (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_cpu_req(i_cpu_req), .o_cpu_rsp(o_cpu_rsp),
		.i_host_req(i_host_req), .o_host_rsp(o_host_rsp),
		.o_req(arb_req), .i_rsp(arb_rsp));

	bus_delay_stage bus_delay_stage_inst (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_req(arb_req), .o_rsp(arb_rsp),
		.o_req(dly_req), .i_rsp(dly_rsp));

	bus_addr_decoder bus_addr_decoder_inst (
		.i_req(dly_req), .o_region(region),
		.o_ram_stb(ram_stb), .o_mem_stb(mem_stb), .o_io_stb(io_stb));

	////////////////////
	// Slaves
	////////////////////
	// External RAM sees only its word offset
	assign o_ram_req = '{cyc: dly_req.cyc, stb: ram_stb, we: dly_req.we,
		addr: {{(BUS_AW-RAM_AW){1'b0}}, dly_req.addr[RAM_AW-1:0]},
		data: dly_req.data, sel: dly_req.sel};

	block_ram_slave block_ram_slave_inst (
		.i_clk(i_clk), .i_stb(mem_stb), .i_req(dly_req), .o_rsp(mem_rsp));

	io_reg_slave io_reg_slave_inst (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_stb(io_stb), .i_req(dly_req),
		.i_err_addr(err_addr), .o_rsp(io_rsp), .o_led(o_led));

	////////////////////
	// Responses
	////////////////////
	bus_response_mux bus_response_mux_inst (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_cyc(dly_req.cyc),
		.i_region(region), .i_ram_rsp(i_ram_rsp), .i_mem_rsp(mem_rsp),
		.i_io_rsp(io_rsp), .o_rsp(mux_rsp), .o_ack_count(ack_count));

	bus_error_monitor bus_error_monitor_inst (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_req(dly_req),
		.i_region(region), .i_ack_count(ack_count), .i_ram_err(i_ram_err),
		.o_err(bus_err), .o_err_addr(err_addr));

	// Merged response with the monitor's error bit
	assign dly_rsp = '{ack: mux_rsp.ack, stall: mux_rsp.stall,
		err: bus_err, data: mux_rsp.data};

endmodule

`default_nettype wire

//--- bus_pkg.sv
// Bus interconnect definitions
// Widths, region decode bits, I/O register map and the request and
// response words shared by masters, interconnect and slaves
`default_nettype none

package bus_pkg;

	////////////////////
	// Bus widths
	////////////////////
	localparam int BUS_AW = 28;
	localparam int BUS_DW = 32;
	localparam int BUS_SW = BUS_DW / 8;

	// External RAM word offset
	localparam int RAM_AW = 26;

	////////////////////
	// Region decode
	////////////////////
	// Checked in this order, bit 27 set selects nothing
	localparam int RAM_REGION_BIT = 26;
	localparam int MEM_REGION_BIT = 15;
	localparam int IO_REGION_BIT  = 8;

	// Block RAM words, mirrored across its region
	localparam int MEM_AW = 10;

	typedef logic [BUS_AW-1:0] bus_addr_t;
	typedef logic [BUS_DW-1:0] bus_data_t;
	typedef logic [BUS_SW-1:0] bus_sel_t;

	// Fixed value read back from the ID register
	localparam bus_data_t IO_ID_VALUE = 32'h5e1f_0c11;

	// One request word, master side or slave side
	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		bus_addr_t addr;
		bus_data_t data;
		bus_sel_t  sel;
	} bus_req_t;

	// Response as a master sees it
	typedef struct packed {
		logic      ack;
		logic      stall;
		logic      err;
		bus_data_t data;
	} bus_rsp_t;

	// Response of a single slave
	typedef struct packed {
		logic      ack;
		logic      stall;
		bus_data_t data;
	} slave_rsp_t;

	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_RAM,
		REGION_MEM,
		REGION_IO
	} region_e;

	// Word offsets within the I/O page
	typedef enum logic [1:0] {
		IO_LED    = 2'd0,
		IO_ID     = 2'd1,
		IO_BUSERR = 2'd2
	} io_reg_e;

	typedef enum logic {
		OWNER_CPU,
		OWNER_HOST
	} owner_e;

endpackage

`default_nettype wire

//--- bus_priority_arbiter.sv
// Two-master priority arbiter
// Grants the shared bus to the processor or the host port for a whole
// bus cycle, processor preferred
`default_nettype none

module bus_priority_arbiter (
	input  wire                    i_clk,
	input  wire                    i_arst_n,
	input  wire bus_pkg::bus_req_t i_cpu_req,
	output bus_pkg::bus_rsp_t      o_cpu_rsp,
	input  wire bus_pkg::bus_req_t i_host_req,
	output bus_pkg::bus_rsp_t      o_host_rsp,
	output bus_pkg::bus_req_t      o_req,
	input  wire bus_pkg::bus_rsp_t i_rsp
);
	import bus_pkg::*;

	owner_e r_owner;
	logic   owner_cyc;

	// Cycle line of whoever holds the grant
	assign owner_cyc = (r_owner == OWNER_CPU) ? i_cpu_req.cyc : i_host_req.cyc;

	// Grant only moves while the owner is idle
	// Falls back to the CPU once both are idle
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			r_owner <= OWNER_CPU;
		else if (!owner_cyc)
			r_owner <= (!i_cpu_req.cyc && i_host_req.cyc) ? OWNER_HOST : OWNER_CPU;
	end

	assign o_req = (r_owner == OWNER_CPU) ? i_cpu_req : i_host_req;

	////////////////////
	// Response routing
	////////////////////
	always_comb
	begin
		o_cpu_rsp  = i_rsp;
		o_host_rsp = i_rsp;
		// Losing master waits, sees no ack or error
		if (r_owner == OWNER_CPU)
		begin
			o_host_rsp.ack   = 1'b0;
			o_host_rsp.err   = 1'b0;
			o_host_rsp.stall = 1'b1;
		end
		else
		begin
			o_cpu_rsp.ack   = 1'b0;
			o_cpu_rsp.err   = 1'b0;
			o_cpu_rsp.stall = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- bus_response_mux.sv
// Response collector
// Registers the merged acknowledge and read data of the three slaves and
// passes the selected slave's stall straight through
`default_nettype none

module bus_response_mux (
	input  wire                      i_clk,
	input  wire                      i_arst_n,
	input  wire                      i_cyc,
	input  wire bus_pkg::region_e    i_region,
	input  wire bus_pkg::slave_rsp_t i_ram_rsp,
	input  wire bus_pkg::slave_rsp_t i_mem_rsp,
	input  wire bus_pkg::slave_rsp_t i_io_rsp,
	output bus_pkg::bus_rsp_t        o_rsp,
	output logic [1:0]               o_ack_count
);
	import bus_pkg::*;

	logic      r_ack;
	bus_data_t r_data;
	logic      stall;

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			r_ack <= 1'b0;
		else
			r_ack <= i_cyc && (i_ram_rsp.ack || i_mem_rsp.ack || i_io_rsp.ack);
	end

	// Fixed priority, RAM first
	always_ff @(posedge i_clk)
	begin
		if (i_ram_rsp.ack)
			r_data <= i_ram_rsp.data;
		else if (i_mem_rsp.ack)
			r_data <= i_mem_rsp.data;
		else
			r_data <= i_io_rsp.data;
	end

	// Stall stays combinational
	always_comb
	begin
		case (i_region)
			REGION_RAM: stall = i_ram_rsp.stall;
			REGION_MEM: stall = i_mem_rsp.stall;
			REGION_IO:  stall = i_io_rsp.stall;
			default:    stall = 1'b0;
		endcase
	end

	// Error bit filled in by the error monitor
	assign o_rsp = '{ack: r_ack, stall: i_cyc && stall, err: 1'b0, data: r_data};

	// Acks this cycle, more than one is a bus fault
	assign o_ack_count = 2'(i_ram_rsp.ack) + 2'(i_mem_rsp.ack) + 2'(i_io_rsp.ack);

endmodule

`default_nettype wire

//--- files.f
bus_pkg.sv
bus_priority_arbiter.sv
bus_delay_stage.sv
bus_addr_decoder.sv
bus_response_mux.sv
bus_error_monitor.sv
block_ram_slave.sv
io_reg_slave.sv
bus_interconnect_top.sv
tb_bus_interconnect.sv

//--- io_reg_slave.sv
// I/O register page
// LED register, fixed ID register and the read-only bus error address
`default_nettype none

module io_reg_slave (
	input  wire                    i_clk,
	input  wire                    i_arst_n,
	input  wire                    i_stb,
	input  wire bus_pkg::bus_req_t i_req,
	input  wire bus_pkg::bus_data_t i_err_addr,
	output bus_pkg::slave_rsp_t    o_rsp,
	output logic [3:0]             o_led
);
	import bus_pkg::*;

	logic      r_ack;
	bus_data_t r_data;
	logic [3:0] r_led;
	io_reg_e   reg_sel;

	assign reg_sel = io_reg_e'(i_req.addr[1:0]);

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			r_ack <= 1'b0;
			r_led <= 4'h0;
		end
		else
		begin
			r_ack <= i_stb;
			// LED bits live in the low byte lane
			if (i_stb && i_req.we && (reg_sel == IO_LED) && i_req.sel[0])
				r_led <= i_req.data[3:0];
		end
	end

	// Read mux, ID and BUSERR ignore writes
	always_ff @(posedge i_clk)
	begin
		case (reg_sel)
			IO_LED:    r_data <= {{(BUS_DW-4){1'b0}}, r_led};
			IO_ID:     r_data <= IO_ID_VALUE;
			IO_BUSERR: r_data <= i_err_addr;
			default:   r_data <= '0;
		endcase
	end

	assign o_rsp = '{ack: r_ack, stall: 1'b0, data: r_data};
	assign o_led = r_led;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then decide pass or fail from the log
verilator --binary --timing -f files.f --top-module tb_bus_interconnect -o tb_sim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
! grep -q "Some tests failed" sim.log && grep -q "All tests passed" sim.log && exit 0 || exit 1

//--- tb_bus_interconnect.sv
// Interconnect testbench
// Two masters, an external RAM responder and a reference model that
// checks every completed transaction
`default_nettype none

module tb_bus_interconnect;
	timeunit 1ns;
	timeprecision 100ps;
	import bus_pkg::*;

	localparam int NUM_TXN = 139;
	localparam int TXN_CYCLES = 60;

	typedef struct packed {
		logic      master;
		logic      we;
		bus_addr_t addr;
		bus_data_t wdata;
		bus_sel_t  sel;
		bus_data_t rdata;
		logic      ack;
		logic      err;
	} done_t;

	logic       i_clk = 1'b0;
	logic       i_arst_n;
	bus_req_t   cpu_req, host_req, o_ram_req;
	bus_rsp_t   o_cpu_rsp, o_host_rsp;
	slave_rsp_t ram_rsp;
	logic       ram_err;
	logic [3:0] o_led;

	bus_data_t  lcg_state = 32'h3a299084;
	done_t      done_q[$];
	int         n_issued = 0;
	int         n_checked = 0;
	int         errors = 0;
	// First completion time of each master
	time        done_time[2] = '{0, 0};
	// Reference state
	bus_data_t  mem_model [2**MEM_AW];
	bus_data_t  ram_model [int];
	bus_data_t  ram_store [int];
	logic [3:0] led_model = 4'h0;
	bus_data_t  err_addr_model = '0;

	bus_interconnect_top bus_interconnect_top_inst (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_cpu_req(cpu_req), .o_cpu_rsp(o_cpu_rsp),
		.i_host_req(host_req), .o_host_rsp(o_host_rsp),
		.o_ram_req(o_ram_req), .i_ram_rsp(ram_rsp), .i_ram_err(ram_err), .o_led(o_led));

	always #4 i_clk = ~i_clk;

	function automatic bus_data_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Contents of an external RAM word never written
	function automatic bus_data_t ram_fill(input int off);
		return (32'(off) * 32'h9e3779b1) ^ 32'hc3a50f1e;
	endfunction

	// Responder refuses offsets with bit 20 set
	function automatic logic ram_bad(input int off);
		return off[20];
	endfunction

	function automatic bus_data_t merge(input bus_data_t old, input bus_data_t d, input bus_sel_t s);
		bus_data_t r;
		r = old;
		for (int i = 0; i < BUS_SW; i++)
			if (s[i])
				r[8*i +: 8] = d[8*i +: 8];
		return r;
	endfunction

	////////////////////
	// Reference model
	////////////////////
	function automatic region_e region_of(input bus_addr_t a);
		if (a[27])
			return REGION_NONE;
		if (a[26])
			return REGION_RAM;
		if (a[15])
			return REGION_MEM;
		if (a[8] && (a[7:0] <= 8'd2))
			return REGION_IO;
		return REGION_NONE;
	endfunction

	function automatic bus_rsp_t ref_read(input bus_addr_t a);
		bus_rsp_t r;
		int off;
		r = '{ack: 1'b1, stall: 1'b0, err: 1'b0, data: '0};
		off = int'(a[RAM_AW-1:0]);
		case (region_of(a))
			REGION_RAM:
			begin
				r.err = ram_bad(off);
				r.data = ram_model.exists(off) ? ram_model[off] : ram_fill(off);
			end
			REGION_MEM: r.data = mem_model[a[MEM_AW-1:0]];
			REGION_IO:
			begin
				if (a[1:0] == 2'd0)
					r.data = {28'd0, led_model};
				else if (a[1:0] == 2'd1)
					r.data = IO_ID_VALUE;
				else
					r.data = err_addr_model;
			end
			default: r.err = 1'b1;
		endcase
		r.ack = !r.err;
		return r;
	endfunction

	task automatic apply_write(input done_t c);
		int off;
		off = int'(c.addr[RAM_AW-1:0]);
		case (region_of(c.addr))
			REGION_RAM: ram_model[off] = merge(ram_model.exists(off) ?
				ram_model[off] : ram_fill(off), c.wdata, c.sel);
			REGION_MEM: mem_model[c.addr[MEM_AW-1:0]] =
				merge(mem_model[c.addr[MEM_AW-1:0]], c.wdata, c.sel);
			REGION_IO:
				if (c.addr[1:0] == 2'd0 && c.sel[0])
					led_model = c.wdata[3:0];
			default: ;
		endcase
	endtask

	////////////////////
	// Checks
	////////////////////
	task automatic report_failure(input string msg);
		errors++;
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_rsp_data(input bus_data_t got, input bus_data_t exp, input string msg);
		if (got !== exp)
			report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, msg, got, exp));
	endtask

	task automatic check_err(input logic got, input logic exp, input string msg);
		if (got !== exp)
			report_failure($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, msg, got, exp));
	endtask

	task automatic check_led(input logic [3:0] got, input logic [3:0] exp, input string msg);
		if (got !== exp)
			report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, msg, got, exp));
	endtask

	// Compares completions in the order they finished
	always @(posedge i_clk)
	begin : compare_proc
		done_t c;
		bus_rsp_t exp;
		while (done_q.size() > 0)
		begin
			c = done_q.pop_front();
			exp = ref_read(c.addr);
			check_err(c.err, exp.err,
				$sformatf("error flag, master %0d addr %h", c.master, c.addr));
			check_err(c.ack, exp.ack,
				$sformatf("ack flag, master %0d addr %h", c.master, c.addr));
			if (!c.we && !c.err)
				check_rsp_data(c.rdata, exp.data,
					$sformatf("read data, master %0d addr %h", c.master, c.addr));
			if (c.err)
				err_addr_model = 32'(c.addr) << 2;
			else if (c.we)
				apply_write(c);
			if (c.we && region_of(c.addr) == REGION_IO)
				check_led(o_led, led_model, "LED output");
			n_checked++;
		end
	end

	////////////////////
	// External RAM
	////////////////////
	// Random stalls and latency over sparse storage
	always @(posedge i_clk)
	begin : ram_responder
		static logic busy = 1'b0;
		static int wait_cnt = 0;
		static bus_req_t held;
		int off;
		ram_rsp.ack <= 1'b0;
		ram_err <= 1'b0;
		// Whole request address used as the offset
		off = int'(held.addr);
		if (busy)
		begin
			if (wait_cnt == 0)
			begin
				busy = 1'b0;
				ram_rsp.stall <= 1'b0;
				if (ram_bad(off))
					ram_err <= 1'b1;
				else
				begin
					ram_rsp.ack <= 1'b1;
					if (held.we)
						ram_store[off] = merge(ram_store.exists(off) ?
							ram_store[off] : ram_fill(off), held.data, held.sel);
					else
						ram_rsp.data <= ram_store.exists(off) ? ram_store[off] : ram_fill(off);
				end
			end
			else
				wait_cnt--;
		end
		else if (o_ram_req.stb && !ram_rsp.stall)
		begin
			held = o_ram_req;
			busy = 1'b1;
			wait_cnt = int'(lcg_next() % 4);
			ram_rsp.stall <= 1'b1;
		end
		else
			ram_rsp.stall <= (lcg_next() % 4 == 0);
	end

	////////////////////
	// Masters
	////////////////////
	task automatic drive_req(input logic m, input bus_req_t rq);
		if (m)
			host_req <= rq;
		else
			cpu_req <= rq;
	endtask

	// One full bus cycle with a single request
	task automatic run_txn(input logic m, input logic we, input bus_addr_t a,
		input bus_data_t d, input bus_sel_t s);
		bus_req_t rq;
		bus_rsp_t rsp;
		rq = '{cyc: 1'b1, stb: 1'b1, we: we, addr: a, data: d, sel: s};
		n_issued++;
		@(posedge i_clk);
		drive_req(m, rq);
		forever
		begin
			@(posedge i_clk);
			rsp = m ? o_host_rsp : o_cpu_rsp;
			if (rsp.ack || rsp.err)
				report_failure("response seen before the request was accepted");
			if (!rsp.stall)
				break;
		end
		rq.stb = 1'b0;
		drive_req(m, rq);
		forever
		begin
			@(posedge i_clk);
			rsp = m ? o_host_rsp : o_cpu_rsp;
			if (rsp.ack || rsp.err)
				break;
		end
		rq.cyc = 1'b0;
		drive_req(m, rq);
		if (done_time[m] == 0)
			done_time[m] = $time;
		done_q.push_back('{master: m, we: we, addr: a, wdata: d, sel: s,
			rdata: rsp.data, ack: rsp.ack, err: rsp.err});
	endtask

	task automatic mem_pair(input logic m, input int idx, input bus_data_t d);
		run_txn(m, 1'b1, {2'b00, 10'd0, 1'b1, 5'd0, 10'(idx)}, d, 4'hf);
		run_txn(m, 1'b0, {2'b00, 10'h155, 1'b1, 5'h0a, 10'(idx)}, '0, 4'hf);
	endtask

	// Watchdog sized from the transaction count
	initial
	begin
		repeat (10 + NUM_TXN * TXN_CYCLES) @(posedge i_clk);
		report_failure("watchdog timeout, transactions did not complete");
	end

	initial
	begin : main_seq
		bus_data_t a;
		bus_data_t b;
		i_arst_n = 1'b0;
		cpu_req = '0;
		host_req = '0;
		ram_rsp = '0;
		ram_err = 1'b0;
		repeat (10) @(posedge i_clk);
		i_arst_n <= 1'b1;
		@(posedge i_clk);
		check_led(o_led, 4'h0, "LED after reset");
		// Block RAM writes then an aliased read
		for (int i = 0; i < 16; i++)
		begin
			a = lcg_next();
			b = lcg_next();
			run_txn(1'b1, 1'b1, {2'b00, a[25:16], 1'b1, a[14:10], a[9:0]}, lcg_next(), 4'hf);
			run_txn(1'b1, 1'b1, {2'b00, b[25:16], 1'b1, b[14:10], a[9:0]}, lcg_next(), b[3:0]);
			run_txn(1'b1, 1'b0, {2'b00, b[31:22], 1'b1, b[20:16], a[9:0]}, '0, 4'hf);
		end
		// External RAM write and readback then an unwritten word
		for (int i = 0; i < 16; i++)
		begin
			a = lcg_next();
			run_txn(1'b1, 1'b1, {2'b01, a[25:0]}, lcg_next(), 4'(lcg_next()));
			run_txn(1'b1, 1'b0, {2'b01, a[25:0]}, '0, 4'hf);
			run_txn(1'b1, 1'b0, {2'b01, 26'(lcg_next())}, '0, 4'hf);
		end
		// Unmapped addresses each followed by a BUSERR read
		a = lcg_next();
		run_txn(1'b1, 1'b0, {1'b1, a[26:0]}, '0, 4'hf);
		run_txn(1'b1, 1'b0, 28'h0000102, '0, 4'hf);
		run_txn(1'b1, 1'b1, 28'h0000103, a, 4'hf);
		run_txn(1'b1, 1'b0, 28'h0000102, '0, 4'hf);
		run_txn(1'b1, 1'b0, 28'h0000180, '0, 4'hf);
		run_txn(1'b1, 1'b0, 28'h0000102, '0, 4'hf);
		run_txn(1'b1, 1'b0, {2'b00, a[25:16], 1'b0, a[14:9], 1'b0, a[7:0]}, '0, 4'hf);
		run_txn(1'b1, 1'b0, 28'h0000102, '0, 4'hf);
		// LED and ID registers
		run_txn(1'b1, 1'b1, 28'h0000100, 32'habcd1235, 4'hf);
		run_txn(1'b1, 1'b0, 28'h0000100, '0, 4'hf);
		run_txn(1'b1, 1'b0, 28'h0000101, '0, 4'hf);
		// Both masters from idle on the same edge
		done_time[0] = 0;
		done_time[1] = 0;
		fork
			for (int i = 0; i < 8; i++)
				mem_pair(1'b0, 512 + i, lcg_next());
			for (int i = 0; i < 8; i++)
				mem_pair(1'b1, 768 + i, lcg_next());
		join
		check_err(done_time[0] < done_time[1], 1'b1, "CPU finishes first");
		repeat (4) @(posedge i_clk);
		if (errors == 0 && n_checked == n_issued)
		begin
			$display("All tests passed");
			$finish;
		end
		else
		begin
			$display("checked %0d of %0d transactions", n_checked, n_issued);
			$display("Some tests failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire
